// File: common/chip8_pkg.sv
`default_nettype none

package chip8_pkg;

  localparam int ADDR_W = 12; // program space is 4 KiB
  localparam int DATA_W = 8;
  localparam int REG_COUNT = 16;
  localparam int REG_VF = 15; // flag register
  localparam int SPRITE_X_W = 6; // 64 columns
  localparam int SPRITE_Y_W = 5; // 32 rows
  localparam int HEIGHT_W = 4;

  // pc after reset, start of the program area
  localparam logic [ADDR_W-1:0] PROG_START = 12'h200;

  // error codes, sticky once set
  localparam logic [2:0] ERR_NONE = 3'd0;
  localparam logic [2:0] ERR_PARSE = 3'd1;

  // address view: 1nnn, Annn, Bnnn
  typedef struct packed {
    logic [3:0] top;
    logic [ADDR_W-1:0] nnn;
  } op_addr_t;

  // register view: kk is y and n together
  typedef struct packed {
    logic [3:0] top;
    logic [3:0] x;
    logic [3:0] y;
    logic [3:0] n;
  } op_reg_t;

  // one opcode word, two decodings
  typedef union packed {
    op_addr_t a;
    op_reg_t r;
  } opcode_t;

  typedef enum logic [4:0] {
    INSTR_NOP, // dropped or unknown opcode
    INSTR_CLS, // 00E0
    INSTR_JP, // 1nnn
    INSTR_SE_IMM, // 3xkk
    INSTR_SNE_IMM, // 4xkk
    INSTR_SE_REG, // 5xy0
    INSTR_LD_IMM, // 6xkk
    INSTR_ADD_IMM, // 7xkk
    INSTR_LD_REG, // 8xy0
    INSTR_OR, // 8xy1
    INSTR_AND, // 8xy2
    INSTR_XOR, // 8xy3
    INSTR_ADD_REG, // 8xy4
    INSTR_SUB, // 8xy5
    INSTR_SNE_REG, // 9xy0
    INSTR_LD_I, // Annn
    INSTR_JP_V0, // Bnnn
    INSTR_DRW // Dxyn
  } instr_e;

endpackage

`default_nettype wire

// File: execute/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input wire clk_in,
  input wire rst_in,
  input wire instr_valid,
  input var chip8_pkg::instr_e instr,
  input var chip8_pkg::opcode_t op,
  input wire [chip8_pkg::ADDR_W-1:0] op_pc,
  output logic pc_done,
  output logic [chip8_pkg::ADDR_W-1:0] next_pc,
  output logic clear_req,
  output logic draw_req,
  output logic [chip8_pkg::ADDR_W-1:0] sprite_addr,
  output logic [chip8_pkg::SPRITE_X_W-1:0] sprite_x,
  output logic [chip8_pkg::SPRITE_Y_W-1:0] sprite_y,
  output logic [chip8_pkg::HEIGHT_W-1:0] sprite_height,
  input wire video_done,
  input wire collision
);

  logic [chip8_pkg::DATA_W-1:0] vx, vy, v0, kk;
  logic [chip8_pkg::ADDR_W-1:0] i_reg;
  logic [chip8_pkg::DATA_W:0] sum; // carry in top bit
  logic alu_wr, alu_flag_wr, skip;
  logic [chip8_pkg::DATA_W-1:0] alu_data, alu_flag;
  logic [chip8_pkg::ADDR_W-1:0] pc_calc;
  logic video_open; // clear or draw waiting for video_done
  logic draw_open;
  logic flag_en;
  logic [chip8_pkg::DATA_W-1:0] flag_data;

  assign kk = {op.r.y, op.r.n};
  assign sum = {1'b0, vx} + {1'b0, vy};

  always_comb begin
    alu_wr = 1'b1;
    alu_flag_wr = 1'b0;
    alu_data = vy;
    alu_flag = '0;
    case (instr)
      chip8_pkg::INSTR_LD_IMM: alu_data = kk;
      chip8_pkg::INSTR_ADD_IMM: alu_data = vx + kk; // no carry flag
      chip8_pkg::INSTR_LD_REG: alu_data = vy;
      chip8_pkg::INSTR_OR: alu_data = vx | vy;
      chip8_pkg::INSTR_AND: alu_data = vx & vy;
      chip8_pkg::INSTR_XOR: alu_data = vx ^ vy;
      chip8_pkg::INSTR_ADD_REG: begin
        alu_data = sum[chip8_pkg::DATA_W-1:0];
        alu_flag_wr = 1'b1;
        alu_flag = {{(chip8_pkg::DATA_W-1){1'b0}}, sum[chip8_pkg::DATA_W]};
      end
      chip8_pkg::INSTR_SUB: begin
        alu_data = vx - vy;
        alu_flag_wr = 1'b1;
        alu_flag = {{(chip8_pkg::DATA_W-1){1'b0}}, vx > vy}; // not borrow
      end
      default: alu_wr = 1'b0;
    endcase
  end

  always_comb begin
    skip = 1'b0;
    pc_calc = op_pc;
    case (instr)
      chip8_pkg::INSTR_SE_IMM: skip = (vx == kk);
      chip8_pkg::INSTR_SNE_IMM: skip = (vx != kk);
      chip8_pkg::INSTR_SE_REG: skip = (vx == vy);
      chip8_pkg::INSTR_SNE_REG: skip = (vx != vy);
      chip8_pkg::INSTR_JP: pc_calc = op.a.nnn;
      chip8_pkg::INSTR_JP_V0: pc_calc = op.a.nnn + {4'h0, v0}; // wraps
      default: skip = 1'b0;
    endcase
    if (skip) begin
      pc_calc = op_pc + 12'd2;
    end
  end

  // draw collision lands when the video unit answers
  assign flag_en = (instr_valid && alu_flag_wr) || (video_done && draw_open);
  assign flag_data = draw_open ? {{(chip8_pkg::DATA_W-1){1'b0}}, collision} : alu_flag;

  register_file regs0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .rd_x(op.r.x),
    .rd_y(op.r.y),
    .vx(vx),
    .vy(vy),
    .v0(v0),
    .i_reg(i_reg),
    .wr_en(instr_valid && alu_wr),
    .wr_idx(op.r.x),
    .wr_data(alu_data),
    .flag_en(flag_en),
    .flag_data(flag_data),
    .i_en(instr_valid && instr == chip8_pkg::INSTR_LD_I),
    .i_data(op.a.nnn)
  );

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc_done <= 1'b0;
      clear_req <= 1'b0;
      draw_req <= 1'b0;
      video_open <= 1'b0;
      draw_open <= 1'b0;
    end else begin
      pc_done <= 1'b0;
      clear_req <= 1'b0;
      draw_req <= 1'b0;
      if (instr_valid) begin
        if (instr == chip8_pkg::INSTR_CLS) begin
          clear_req <= 1'b1;
          video_open <= 1'b1;
        end else if (instr == chip8_pkg::INSTR_DRW) begin
          draw_req <= 1'b1;
          video_open <= 1'b1;
          draw_open <= 1'b1;
        end else begin
          pc_done <= 1'b1; // single cycle kinds
        end
      end else if (video_open && video_done) begin
        pc_done <= 1'b1;
        video_open <= 1'b0;
        draw_open <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (instr_valid) begin
      next_pc <= pc_calc;
      if (instr == chip8_pkg::INSTR_DRW) begin // held until video_done
        sprite_addr <= i_reg;
        sprite_x <= vx[chip8_pkg::SPRITE_X_W-1:0];
        sprite_y <= vy[chip8_pkg::SPRITE_Y_W-1:0];
        sprite_height <= op.r.n;
      end
    end
  end

  // fetch must not start a new instruction before the video answer
  assert property (@(posedge clk_in) disable iff (rst_in)
    video_open |-> !instr_valid);

endmodule

`default_nettype wire

// File: execute/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input wire clk_in,
  input wire rst_in,
  input wire [3:0] rd_x,
  input wire [3:0] rd_y,
  output logic [chip8_pkg::DATA_W-1:0] vx,
  output logic [chip8_pkg::DATA_W-1:0] vy,
  output logic [chip8_pkg::DATA_W-1:0] v0,
  output logic [chip8_pkg::ADDR_W-1:0] i_reg,
  input wire wr_en,
  input wire [3:0] wr_idx,
  input wire [chip8_pkg::DATA_W-1:0] wr_data,
  input wire flag_en,
  input wire [chip8_pkg::DATA_W-1:0] flag_data,
  input wire i_en,
  input wire [chip8_pkg::ADDR_W-1:0] i_data
);

  logic [chip8_pkg::DATA_W-1:0] regs [chip8_pkg::REG_COUNT]; // V0 to VF

  assign vx = regs[rd_x];
  assign vy = regs[rd_y];
  assign v0 = regs[0];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < chip8_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      i_reg <= '0;
    end else begin
      if (wr_en) begin
        regs[wr_idx] <= wr_data;
      end
      if (flag_en) begin
        regs[chip8_pkg::REG_VF] <= flag_data; // later write wins on VF
      end
      if (i_en) begin
        i_reg <= i_data;
      end
    end
  end

endmodule

`default_nettype wire

// File: fetch/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
  input wire clk_in,
  input wire rst_in,
  input wire step,
  input wire pc_done,
  input wire [chip8_pkg::ADDR_W-1:0] next_pc,
  output logic [chip8_pkg::ADDR_W-1:0] mem_addr,
  output logic mem_valid,
  input wire mem_ready,
  input wire mem_rvalid,
  input wire [chip8_pkg::DATA_W-1:0] mem_rdata,
  output logic op_valid,
  output chip8_pkg::opcode_t op,
  output logic [chip8_pkg::ADDR_W-1:0] op_pc
);

  typedef enum logic [1:0] {
    S_IDLE, // waiting for step
    S_FETCH, // requesting and collecting bytes
    S_EXEC // instruction in flight downstream
  } state_e;

  state_e state;
  logic [chip8_pkg::ADDR_W-1:0] pc;
  logic [1:0] req_cnt; // requests accepted so far
  logic [1:0] rsp_cnt; // bytes returned so far
  logic [1:0] outstanding;
  logic [chip8_pkg::DATA_W-1:0] hi_byte;
  logic accept;

  assign mem_valid = (state == S_FETCH) && (req_cnt != 2'd2);
  assign mem_addr = pc + {{(chip8_pkg::ADDR_W-2){1'b0}}, req_cnt}; // wraps at 4096
  assign accept = mem_valid && mem_ready;
  assign outstanding = req_cnt - rsp_cnt;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= S_IDLE;
      pc <= chip8_pkg::PROG_START;
      req_cnt <= 2'd0;
      rsp_cnt <= 2'd0;
      op_valid <= 1'b0;
    end else begin
      op_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (step) begin
            state <= S_FETCH;
            req_cnt <= 2'd0;
            rsp_cnt <= 2'd0;
          end
        end
        S_FETCH: begin
          if (accept) begin
            req_cnt <= req_cnt + 2'd1;
          end
          if (mem_rvalid) begin
            rsp_cnt <= rsp_cnt + 2'd1;
            if (rsp_cnt == 2'd1) begin // low byte closes the fetch
              op_valid <= 1'b1;
              state <= S_EXEC;
            end
          end
        end
        S_EXEC: begin
          if (pc_done) begin
            pc <= next_pc;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // opcode bytes arrive high first
  always_ff @(posedge clk_in) begin
    if (state == S_FETCH && mem_rvalid) begin
      if (rsp_cnt == 2'd0) begin
        hi_byte <= mem_rdata;
      end else begin
        op <= {hi_byte, mem_rdata};
        op_pc <= pc + 12'd2;
      end
    end
  end

  // request must hold while the memory stalls
  assert property (@(posedge clk_in) disable iff (rst_in)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr));

  // two bytes in flight at most, and no answer without a request
  assert property (@(posedge clk_in) disable iff (rst_in)
    (outstanding <= 2'd2) && !(mem_rvalid && outstanding == 2'd0));

endmodule

`default_nettype wire

// File: sim/tb_chip8.sv
`timescale 1ns/100ps
`default_nettype none

module tb_chip8;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_STEPS = 400;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_STEPS * 200;

  logic clk_in, rst_in, step;
  logic [11:0] mem_addr, sprite_addr;
  logic mem_valid, mem_ready, mem_rvalid, clear_req, draw_req, video_done, collision;
  logic [7:0] mem_rdata;
  logic [5:0] sprite_x;
  logic [4:0] sprite_y;
  logic [3:0] sprite_height;
  logic [2:0] error_out;

  logic [7:0] m_v [16]; // reference model state
  logic [11:0] m_pc, m_i;
  logic [2:0] m_err;
  logic [11:0] fetch_q [$]; // accepted fetch addresses of this step
  int clear_cnt, draw_cnt, mismatches, seed, scratch;
  logic [11:0] seen_addr;
  logic [5:0] seen_x;
  logic [4:0] seen_y;
  logic [3:0] seen_h;
  logic seen_coll;

  chip8_top dut0 (
    .clk_in(clk_in), .rst_in(rst_in), .step(step),
    .mem_addr(mem_addr), .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .clear_req(clear_req), .draw_req(draw_req), .sprite_addr(sprite_addr),
    .sprite_x(sprite_x), .sprite_y(sprite_y), .sprite_height(sprite_height),
    .video_done(video_done), .collision(collision), .error_out(error_out)
  );

  mem_video_responder resp0 (
    .clk_in(clk_in), .rst_in(rst_in), .mem_addr(mem_addr), .mem_valid(mem_valid),
    .mem_ready(mem_ready), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .clear_req(clear_req), .draw_req(draw_req), .video_done(video_done),
    .collision(collision)
  );

  initial clk_in = 1'b0;
  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  // edge sampling sees the values of the cycle just ended
  always @(posedge clk_in) begin
    if (!rst_in) begin
      if (mem_valid && mem_ready) fetch_q.push_back(mem_addr);
      if (clear_req) clear_cnt = clear_cnt + 1;
      if (draw_req) begin
        draw_cnt = draw_cnt + 1;
        seen_addr = sprite_addr;
        seen_x = sprite_x;
        seen_y = sprite_y;
        seen_h = sprite_height;
      end
      if (video_done) seen_coll = collision;
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      mismatches = mismatches + 1;
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // mostly kept instructions, one in ten dropped
  function automatic logic [15:0] random_opcode();
    int pick;
    logic [3:0] x, y;
    logic [7:0] kk;
    logic [11:0] nnn;
    pick = $urandom_range(0, 99);
    x = $urandom_range(0, 15);
    y = $urandom_range(0, 15);
    kk = $urandom_range(0, 255);
    nnn = $urandom_range(0, 4095);
    if (pick < 4) return 16'h00E0;
    if (pick < 8) return {4'h1, nnn};
    if (pick < 16) return {4'h3, x, kk};
    if (pick < 24) return {4'h4, x, kk};
    if (pick < 30) return {4'h5, x, y, 4'h0};
    if (pick < 38) return {4'h6, x, kk};
    if (pick < 46) return {4'h7, x, kk};
    if (pick < 66) return {4'h8, x, y, 4'($urandom_range(0, 5))};
    if (pick < 70) return {4'h9, x, y, 4'h0};
    if (pick < 76) return {4'hA, nnn};
    if (pick < 79) return {4'hB, nnn};
    if (pick < 90) return {4'hD, x, kk};
    case ($urandom_range(0, 5))
      0: return 16'h00EE; // return
      1: return {4'h2, nnn}; // call
      2: return {4'hC, x, kk}; // random
      3: return {4'h8, x, y, 4'h6}; // shift
      4: return {4'hE, x, 8'h9E}; // key skip
      default: return {4'hF, x, 8'h07}; // timer read
    endcase
  endfunction

  task automatic model_step;
    logic [15:0] opw;
    logic [11:0] lo_addr, nxt;
    logic [3:0] x, y, n;
    logic [7:0] kk, vx, vy;
    logic [8:0] sum;
    logic skip;
    int exp_clear, exp_draw;
    lo_addr = m_pc + 12'd1;
    opw = {resp0.prog[m_pc], resp0.prog[lo_addr]};
    x = opw[11:8];
    y = opw[7:4];
    n = opw[3:0];
    kk = opw[7:0];
    vx = m_v[x];
    vy = m_v[y];
    nxt = m_pc + 12'd2;
    skip = 1'b0;
    exp_clear = 0;
    exp_draw = 0;
    check("fetch count", fetch_q.size(), 2);
    if (fetch_q.size() == 2) begin
      check("mem_addr high byte", fetch_q[0], m_pc);
      check("mem_addr low byte", fetch_q[1], lo_addr);
    end
    case (opw[15:12])
      4'h0: begin
        if (opw[11:0] == 12'h0E0) exp_clear = 1;
        else m_err = chip8_pkg::ERR_PARSE;
      end
      4'h1: nxt = opw[11:0];
      4'h3: skip = (vx == kk);
      4'h4: skip = (vx != kk);
      4'h5: begin
        if (n == 4'h0) skip = (vx == vy);
        else m_err = chip8_pkg::ERR_PARSE;
      end
      4'h6: m_v[x] = kk;
      4'h7: m_v[x] = vx + kk;
      4'h8: begin
        case (n)
          4'h0: m_v[x] = vy;
          4'h1: m_v[x] = vx | vy;
          4'h2: m_v[x] = vx & vy;
          4'h3: m_v[x] = vx ^ vy;
          4'h4: begin
            sum = {1'b0, vx} + {1'b0, vy};
            m_v[x] = sum[7:0];
            m_v[15] = {7'd0, sum[8]}; // flag wins over VF result
          end
          4'h5: begin
            m_v[x] = vx - vy;
            m_v[15] = {7'd0, vx > vy};
          end
          default: m_err = chip8_pkg::ERR_PARSE;
        endcase
      end
      4'h9: begin
        if (n == 4'h0) skip = (vx != vy);
        else m_err = chip8_pkg::ERR_PARSE;
      end
      4'hA: m_i = opw[11:0];
      4'hB: nxt = opw[11:0] + {4'h0, m_v[0]};
      4'hD: begin
        exp_draw = 1;
        check("sprite_addr", seen_addr, m_i);
        check("sprite_x", seen_x, vx[5:0]);
        check("sprite_y", seen_y, vy[4:0]);
        check("sprite_height", seen_h, n);
        m_v[15] = {7'd0, seen_coll};
      end
      default: m_err = chip8_pkg::ERR_PARSE;
    endcase
    if (skip) nxt = m_pc + 12'd4;
    check("clear_req count", clear_cnt, exp_clear);
    check("draw_req count", draw_cnt, exp_draw);
    check("error_out", error_out, m_err);
    m_pc = nxt;
  endtask

  task automatic run_step;
    @(negedge clk_in);
    fetch_q.delete();
    clear_cnt = 0;
    draw_cnt = 0;
    step = 1'b1;
    @(negedge clk_in);
    step = 1'b0;
    @(posedge clk_in);
    while (!dut0.pc_done) @(posedge clk_in); // end of the instruction
    @(negedge clk_in);
    model_step();
  endtask

  initial begin
    seed = 5;
    scratch = $urandom(seed);
    rst_in = 1'b1;
    step = 1'b0;
    mismatches = 0;
    clear_cnt = 0;
    draw_cnt = 0;
    for (int a = 0; a < 4096; a += 2) begin
      scratch = random_opcode();
      resp0.prog[a] = scratch[15:8];
      resp0.prog[a + 1] = scratch[7:0];
    end
    for (int r = 0; r < 16; r++) m_v[r] = 8'h00;
    m_pc = chip8_pkg::PROG_START;
    m_i = 12'h000;
    m_err = chip8_pkg::ERR_NONE;
    repeat (RESET_CYCLES) @(negedge clk_in);
    rst_in = 1'b0;
    @(posedge clk_in);
    check("mem_valid after reset", mem_valid, 1'b0);
    check("clear_req after reset", clear_req, 1'b0);
    check("draw_req after reset", draw_req, 1'b0);
    check("error_out after reset", error_out, chip8_pkg::ERR_NONE);
    for (int s = 0; s < NUM_STEPS; s++) run_step();
    $display("%0d mismatches in %0d steps", mismatches, NUM_STEPS);
    if (mismatches == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_in);
    $display("The run timed out after %0d cycles, an instruction never finished",
             TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_responders.sv
`timescale 1ns/100ps
`default_nettype none

module mem_video_responder (
  input wire clk_in,
  input wire rst_in,
  input wire [11:0] mem_addr,
  input wire mem_valid,
  output logic mem_ready,
  output logic mem_rvalid,
  output logic [7:0] mem_rdata,
  input wire clear_req,
  input wire draw_req,
  output logic video_done,
  output logic collision
);

  logic [7:0] prog [4096]; // filled by the testbench top
  logic [11:0] pend_addr [$]; // accepted requests, oldest first
  int pend_due [$];
  logic [11:0] rd_addr;
  int cycle;
  logic video_busy;
  int video_wait;
  logic coll_bit;

  initial begin
    mem_ready = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata = 8'h00;
    video_done = 1'b0;
    collision = 1'b0;
    cycle = 0;
    video_busy = 1'b0;
    video_wait = 0;
    coll_bit = 1'b0;
  end

  // DUT outputs are stable here, so requests are read and answers driven
  always @(negedge clk_in) begin
    cycle = cycle + 1;
    if (rst_in) begin
      pend_addr.delete();
      pend_due.delete();
      mem_ready = 1'b0;
      mem_rvalid = 1'b0;
      video_done = 1'b0;
      video_busy = 1'b0;
    end else begin
      mem_rvalid = 1'b0;
      if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin // strictly in order
        rd_addr = pend_addr.pop_front();
        void'(pend_due.pop_front());
        mem_rvalid = 1'b1;
        mem_rdata = prog[rd_addr];
      end
      mem_ready = ($urandom_range(0, 3) != 0);
      if (mem_valid && mem_ready) begin // accepted at the next rising edge
        pend_addr.push_back(mem_addr);
        pend_due.push_back(cycle + $urandom_range(1, 4));
      end

      video_done = 1'b0;
      if (video_busy) begin
        if (video_wait == 0) begin
          video_done = 1'b1;
          collision = coll_bit;
          video_busy = 1'b0;
        end else begin
          video_wait = video_wait - 1;
        end
      end
      if (clear_req || draw_req) begin
        video_busy = 1'b1;
        video_wait = $urandom_range(0, 3);
        coll_bit = $urandom_range(0, 1);
      end
    end
  end

endmodule

`default_nettype wire

// File: sources.f
common/chip8_pkg.sv
src/decode_stage.sv
fetch/fetch_stage.sv
execute/register_file.sv
execute/execute_stage.sv
src/chip8_top.sv
sim/tb_responders.sv
sim/tb_chip8.sv

// File: src/chip8_top.sv
`timescale 1ns/100ps
`default_nettype none

module chip8_top (
  input wire clk_in,
  input wire rst_in,
  input wire step, // run one instruction

  // program memory, read only
  output logic [chip8_pkg::ADDR_W-1:0] mem_addr,
  output logic mem_valid,
  input wire mem_ready,
  input wire mem_rvalid,
  input wire [chip8_pkg::DATA_W-1:0] mem_rdata,

  // video unit
  output logic clear_req,
  output logic draw_req,
  output logic [chip8_pkg::ADDR_W-1:0] sprite_addr,
  output logic [chip8_pkg::SPRITE_X_W-1:0] sprite_x,
  output logic [chip8_pkg::SPRITE_Y_W-1:0] sprite_y,
  output logic [chip8_pkg::HEIGHT_W-1:0] sprite_height,
  input wire video_done,
  input wire collision,

  output logic [2:0] error_out
);

  // fetch to decode
  logic op_valid;
  chip8_pkg::opcode_t op;
  logic [chip8_pkg::ADDR_W-1:0] op_pc;

  // decode to execute
  logic instr_valid;
  chip8_pkg::instr_e instr;
  chip8_pkg::opcode_t dec_op;
  logic [chip8_pkg::ADDR_W-1:0] dec_pc;

  // execute back to fetch
  logic pc_done;
  logic [chip8_pkg::ADDR_W-1:0] next_pc;

  fetch_stage fetch0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .step(step),
    .pc_done(pc_done),
    .next_pc(next_pc),
    .mem_addr(mem_addr),
    .mem_valid(mem_valid),
    .mem_ready(mem_ready),
    .mem_rvalid(mem_rvalid),
    .mem_rdata(mem_rdata),
    .op_valid(op_valid),
    .op(op),
    .op_pc(op_pc)
  );

  decode_stage decode0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .op_valid(op_valid),
    .op(op),
    .op_pc(op_pc),
    .instr_valid(instr_valid),
    .instr(instr),
    .op_q(dec_op),
    .pc_q(dec_pc),
    .error_out(error_out)
  );

  execute_stage execute0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .instr_valid(instr_valid),
    .instr(instr),
    .op(dec_op),
    .op_pc(dec_pc),
    .pc_done(pc_done),
    .next_pc(next_pc),
    .clear_req(clear_req),
    .draw_req(draw_req),
    .sprite_addr(sprite_addr),
    .sprite_x(sprite_x),
    .sprite_y(sprite_y),
    .sprite_height(sprite_height),
    .video_done(video_done),
    .collision(collision)
  );

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input wire clk_in,
  input wire rst_in,
  input wire op_valid,
  input var chip8_pkg::opcode_t op,
  input wire [chip8_pkg::ADDR_W-1:0] op_pc,
  output logic instr_valid,
  output chip8_pkg::instr_e instr,
  output chip8_pkg::opcode_t op_q,
  output logic [chip8_pkg::ADDR_W-1:0] pc_q,
  output logic [2:0] error_out
);

  chip8_pkg::instr_e kind;

  // classify on the top nibble, then refine through either view
  always_comb begin
    kind = chip8_pkg::INSTR_NOP;
    case (op.r.top)
      4'h0: begin
        if (op.a.nnn == 12'h0E0) begin // only CLS is kept
          kind = chip8_pkg::INSTR_CLS;
        end
      end
      4'h1: kind = chip8_pkg::INSTR_JP;
      4'h3: kind = chip8_pkg::INSTR_SE_IMM;
      4'h4: kind = chip8_pkg::INSTR_SNE_IMM;
      4'h5: begin
        if (op.r.n == 4'h0) begin
          kind = chip8_pkg::INSTR_SE_REG;
        end
      end
      4'h6: kind = chip8_pkg::INSTR_LD_IMM;
      4'h7: kind = chip8_pkg::INSTR_ADD_IMM;
      4'h8: begin
        case (op.r.n)
          4'h0: kind = chip8_pkg::INSTR_LD_REG;
          4'h1: kind = chip8_pkg::INSTR_OR;
          4'h2: kind = chip8_pkg::INSTR_AND;
          4'h3: kind = chip8_pkg::INSTR_XOR;
          4'h4: kind = chip8_pkg::INSTR_ADD_REG;
          4'h5: kind = chip8_pkg::INSTR_SUB;
          default: kind = chip8_pkg::INSTR_NOP; // shifts, SUBN
        endcase
      end
      4'h9: begin
        if (op.r.n == 4'h0) begin
          kind = chip8_pkg::INSTR_SNE_REG;
        end
      end
      4'hA: kind = chip8_pkg::INSTR_LD_I;
      4'hB: kind = chip8_pkg::INSTR_JP_V0;
      4'hD: kind = chip8_pkg::INSTR_DRW;
      default: kind = chip8_pkg::INSTR_NOP; // call, rnd, Ex, Fx
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      instr_valid <= 1'b0;
      error_out <= chip8_pkg::ERR_NONE;
    end else begin
      instr_valid <= op_valid;
      if (op_valid && kind == chip8_pkg::INSTR_NOP) begin
        error_out <= chip8_pkg::ERR_PARSE; // sticky until reset
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (op_valid) begin
      instr <= kind;
      op_q <= op;
      pc_q <= op_pc;
    end
  end

endmodule

`default_nettype wire
